// ==== design/usb_bit_unstuffer.sv ====
`timescale 1ns/10ps
`include "usb_rx_defs.svh"

module usb_bit_unstuffer import usb_rx_pkg::*; (
  input  logic    tb_clk,
  input  logic    rst,
  input  rx_bit_t line_bit,
  output rx_bit_t clean_bit,
  output logic    stuff_err
);

  localparam int unsigned RUN_W = $clog2(`USB_STUFF_RUN + 1);
  typedef logic [RUN_W-1:0] run_t;
  localparam run_t RUN_MAX = run_t'(`USB_STUFF_RUN);

  run_t run_cnt;   // ones in a row
  logic run_full;  // next bit is the stuffed one

  assign run_full = run_cnt == RUN_MAX;

  // stuffed bit is dropped, everything else passes
  assign clean_bit.strobe = line_bit.strobe && !run_full;
  assign clean_bit.data   = line_bit.data;
  assign clean_bit.eop    = line_bit.eop;

  // a seventh one where the zero should be
  assign stuff_err = line_bit.strobe && run_full && line_bit.data;

  always_ff @(posedge tb_clk) begin
    if (rst || line_bit.eop) begin
      run_cnt <= '0;
    end else if (line_bit.strobe) begin
      if (run_full || !line_bit.data) begin
        run_cnt <= '0;  // restart after stuffed bit or a zero
      end else begin
        run_cnt <= run_cnt + run_t'(1);
      end
    end
  end

endmodule

// ==== design/usb_crc_checker.sv ====
`timescale 1ns/10ps
`include "usb_rx_defs.svh"

module usb_crc_checker import usb_rx_pkg::*; (
  input  logic    tb_clk,
  input  logic    rst,
  input  rx_bit_t clean_bit,
  input  logic    crc_clear,
  output logic    crc5_ok,
  output logic    crc16_ok
);

  typedef logic [4:0]  crc5_t;
  typedef logic [15:0] crc16_t;

  crc5_t  crc5;
  crc16_t crc16;
  logic   fb5;   // feedback, bit xor msb
  logic   fb16;

  assign fb5  = clean_bit.data ^ crc5[4];
  assign fb16 = clean_bit.data ^ crc16[15];

  // **************************************************
  // both registers run on every bit after the pid
  // **************************************************
  always_ff @(posedge tb_clk) begin
    if (rst || crc_clear) begin
      crc5  <= '1;  // preset all ones
      crc16 <= '1;
    end else if (clean_bit.strobe) begin
      crc5  <= {crc5[3:0], 1'b0} ^ (fb5 ? `USB_CRC5_POLY : 5'd0);
      crc16 <= {crc16[14:0], 1'b0} ^ (fb16 ? `USB_CRC16_POLY : 16'd0);
    end
  end

  // only one of these matters per packet kind
  assign crc5_ok  = crc5 == `USB_CRC5_RESIDUE;
  assign crc16_ok = crc16 == `USB_CRC16_RESIDUE;

endmodule

// ==== design/usb_line_sampler.sv ====
`timescale 1ns/10ps
`include "usb_rx_defs.svh"

module usb_line_sampler import usb_rx_pkg::*; (
  input  logic    tb_clk,
  input  logic    rst,
  input  logic    d_plus,
  input  logic    d_minus,
  output rx_bit_t line_bit
);

  localparam int unsigned TMR_W = $clog2(`USB_BIT_CLKS);
  typedef logic [TMR_W-1:0] tmr_t;
  localparam tmr_t TMR_LAST = tmr_t'(`USB_BIT_CLKS - 1);
  localparam tmr_t TMR_MID  = tmr_t'(`USB_BIT_CLKS / 2 - 1);  // 4 clocks past the edge

  logic [1:0] line_m;    // {d_plus, d_minus}, first stage
  logic [1:0] line_s;    // synchronized
  logic [1:0] line_q;    // last cycle, for edge detect
  tmr_t       bit_tmr;
  logic       edge_seen;
  logic       mid_bit;
  logic       is_se0;
  logic       ref_j;     // nrzi reference level, 1 = J
  logic       se0_seen;
  logic       active;    // inside a packet

  // **************************************************
  // synchronizer and bit timing
  // **************************************************
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      line_m <= 2'b10;  // idle J
      line_s <= 2'b10;
      line_q <= 2'b10;
    end else begin
      line_m <= {d_plus, d_minus};
      line_s <= line_m;
      line_q <= line_s;
    end
  end

  assign edge_seen = line_s != line_q;
  assign mid_bit   = !edge_seen && (bit_tmr == TMR_MID);
  assign is_se0    = line_s == 2'b00;

  // free running, re-centred on every transition
  always_ff @(posedge tb_clk) begin
    if (rst || edge_seen || bit_tmr == TMR_LAST) begin
      bit_tmr <= '0;
    end else begin
      bit_tmr <= bit_tmr + tmr_t'(1);
    end
  end

  // **************************************************
  // nrzi decode and eop
  // **************************************************
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      line_bit <= '0;
      ref_j    <= 1'b1;
      se0_seen <= 1'b0;
      active   <= 1'b0;
    end else begin
      line_bit <= '0;  // pulses only
      if (mid_bit) begin
        if (is_se0) begin
          se0_seen <= 1'b1;  // no bit for se0
        end else if (se0_seen) begin
          line_bit.eop <= 1'b1;  // first J after se0
          se0_seen     <= 1'b0;
          active       <= 1'b0;
          ref_j        <= 1'b1;  // back to idle J
        end else begin
          ref_j <= line_s[1];
          // idle J gives ones, the first K opens the packet
          if (active || line_s[1] != ref_j) begin
            line_bit.strobe <= 1'b1;
            line_bit.data   <= line_s[1] == ref_j;  // no change = 1
            active          <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== design/usb_rx.sv ====
`timescale 1ns/10ps

module usb_rx import usb_rx_pkg::*; (
  input  logic       tb_clk,
  input  logic       rst,
  input  logic       d_plus,
  input  logic       d_minus,
  output rx_packet_t rx_packet,
  output logic       store_rx_packet_data,
  output usb_byte_t  rx_packet_data
);

  rx_bit_t line_bit;   // raw decoded bits
  rx_bit_t clean_bit;  // stuffing removed
  logic    stuff_err;
  logic    crc_clear;
  logic    crc5_ok;
  logic    crc16_ok;

  // **************************************************
  // receive chain
  // **************************************************
  usb_line_sampler u_line_sampler (
    .tb_clk   (tb_clk),
    .rst      (rst),
    .d_plus   (d_plus),
    .d_minus  (d_minus),
    .line_bit (line_bit)
  );

  usb_bit_unstuffer u_bit_unstuffer (
    .tb_clk    (tb_clk),
    .rst       (rst),
    .line_bit  (line_bit),
    .clean_bit (clean_bit),
    .stuff_err (stuff_err)
  );

  usb_crc_checker u_crc_checker (
    .tb_clk    (tb_clk),
    .rst       (rst),
    .clean_bit (clean_bit),
    .crc_clear (crc_clear),
    .crc5_ok   (crc5_ok),
    .crc16_ok  (crc16_ok)
  );

  usb_rx_fsm u_rx_fsm (
    .tb_clk               (tb_clk),
    .rst                  (rst),
    .clean_bit            (clean_bit),
    .stuff_err            (stuff_err),
    .crc5_ok              (crc5_ok),
    .crc16_ok             (crc16_ok),
    .crc_clear            (crc_clear),
    .rx_packet            (rx_packet),
    .store_rx_packet_data (store_rx_packet_data),
    .rx_packet_data       (rx_packet_data)
  );

endmodule

// ==== design/usb_rx_defs.svh ====
`ifndef USB_RX_DEFS_SVH
`define USB_RX_DEFS_SVH

// bus timing, clocks per bit (shortened for sim)
`define USB_BIT_CLKS 8

// sync pattern, received msb first
`define USB_SYNC_BYTE 8'h01

// fixed device identity
`define USB_DEV_ADDR 7'd0
`define USB_DEV_ENDP 4'd0

// crc generators, msb first shift
`define USB_CRC5_POLY  5'b00101
`define USB_CRC16_POLY 16'h8005

// remainders left after data plus inverted crc
`define USB_CRC5_RESIDUE  5'b01100
`define USB_CRC16_RESIDUE 16'h800D

// ones in a row before a stuffed zero
`define USB_STUFF_RUN 6

`endif

// ==== design/usb_rx_fsm.sv ====
`timescale 1ns/10ps
`include "usb_rx_defs.svh"

module usb_rx_fsm import usb_rx_pkg::*; (
  input  logic       tb_clk,
  input  logic       rst,
  input  rx_bit_t    clean_bit,
  input  logic       stuff_err,
  input  logic       crc5_ok,
  input  logic       crc16_ok,
  output logic       crc_clear,
  output rx_packet_t rx_packet,
  output logic       store_rx_packet_data,
  output usb_byte_t  rx_packet_data
);

  // addr and endp as they sit in the two token bytes
  localparam logic [10:0] DEV_TOKEN = {`USB_DEV_ADDR, `USB_DEV_ENDP};

  rx_state_t  state;
  usb_byte_t  shift_reg;
  usb_byte_t  new_byte;    // shift_reg with this bit added
  usb_byte_t  dly_new;     // payload delay line
  usb_byte_t  dly_old;
  usb_pid_t   pid;
  usb_pid_t   rx_pid;
  logic [2:0] bit_cnt;
  logic [1:0] dly_cnt;     // bytes held in the delay line
  logic       byte_done;
  logic       pid_ok;
  logic       tok_second;
  logic       tok_match;
  logic       bad;         // sticky packet error
  rx_packet_t eop_kind;

  assign new_byte  = {shift_reg[6:0], clean_bit.data};
  assign byte_done = clean_bit.strobe && (bit_cnt == 3'd7);
  assign rx_pid    = usb_pid_t'(new_byte[7:4]);
  assign pid_ok    = new_byte[7:4] == ~new_byte[3:0];  // check nibble

  // **************************************************
  // result picked at eop
  // **************************************************
  always_comb begin
    eop_kind = PKT_BAD;
    if (!bad) begin
      case (state)
        DATA: if (bit_cnt == 3'd0 && dly_cnt == 2'd2 && crc16_ok) eop_kind = PKT_DATA;
        HSHAKE: eop_kind = (pid == ACK) ? PKT_ACK : PKT_NAK;
        WAIT_EOP: begin
          if (crc5_ok) begin
            if (!tok_match) eop_kind = PKT_IDLE;  // not ours
            else if (pid == IN) eop_kind = PKT_IN;
            else eop_kind = PKT_OUT;
          end
        end
        default: eop_kind = PKT_BAD;  // cut short in pid or token
      endcase
    end
  end

  // byte shift and payload delay line
  always_ff @(posedge tb_clk) begin
    if (clean_bit.strobe) begin
      shift_reg <= (state == IDLE) ? {7'd0, clean_bit.data} : new_byte;
    end
    if (state == PID && byte_done) pid <= rx_pid;
    if (state == DATA && byte_done) begin
      dly_old <= dly_new;
      dly_new <= new_byte;
    end
  end

  // **************************************************
  // packet fsm
  // **************************************************
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      state                <= IDLE;
      bit_cnt              <= 3'd0;
      dly_cnt              <= 2'd0;
      tok_second           <= 1'b0;
      tok_match            <= 1'b0;
      bad                  <= 1'b0;
      crc_clear            <= 1'b0;
      rx_packet            <= PKT_IDLE;
      store_rx_packet_data <= 1'b0;
      rx_packet_data       <= '0;
    end else begin
      crc_clear            <= 1'b0;
      store_rx_packet_data <= 1'b0;
      if (clean_bit.strobe) bit_cnt <= bit_cnt + 3'd1;
      if (stuff_err) bad <= 1'b1;
      if (clean_bit.eop) begin
        state <= DONE;
        if (state != IDLE && state != SYNC) rx_packet <= eop_kind;
      end else begin
        case (state)
          IDLE: if (clean_bit.strobe) state <= SYNC;
          SYNC: begin
            if (clean_bit.strobe && new_byte == `USB_SYNC_BYTE) begin
              state     <= PID;
              bit_cnt   <= 3'd0;     // byte aligned from here
              rx_packet <= PKT_IDLE;
            end
          end
          PID: begin
            if (byte_done) begin
              crc_clear <= 1'b1;  // crc covers bytes after the pid
              if (!pid_ok) begin
                bad   <= 1'b1;
                state <= WAIT_EOP;
              end else begin
                case (rx_pid)
                  OUT, IN:      state <= TOKEN;
                  DATA0, DATA1: state <= DATA;
                  ACK, NAK:     state <= HSHAKE;
                  default: begin
                    bad   <= 1'b1;  // unsupported pid
                    state <= WAIT_EOP;
                  end
                endcase
              end
            end
          end
          TOKEN: begin
            if (byte_done) begin
              tok_second <= 1'b1;
              if (!tok_second) begin
                tok_match <= new_byte == DEV_TOKEN[10:3];
              end else begin
                tok_match <= tok_match && (new_byte[7:5] == DEV_TOKEN[2:0]);
                state     <= WAIT_EOP;
              end
            end
          end
          DATA: begin
            if (byte_done) begin
              if (dly_cnt == 2'd2) begin
                store_rx_packet_data <= 1'b1;  // two bytes behind
                rx_packet_data       <= dly_old;
              end else begin
                dly_cnt <= dly_cnt + 2'd1;
              end
            end
          end
          HSHAKE, WAIT_EOP: if (clean_bit.strobe) bad <= 1'b1;  // extra bits
          DONE: begin
            state      <= IDLE;
            bad        <= 1'b0;
            dly_cnt    <= 2'd0;
            tok_second <= 1'b0;
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

endmodule

// ==== design/usb_rx_pkg.sv ====
package usb_rx_pkg;

  typedef logic [7:0] usb_byte_t;  // one packet byte

  // pid codes as sent in the upper nibble
  typedef enum logic [3:0] {
    OUT   = 4'b0001,
    IN    = 4'b1001,
    DATA0 = 4'b0011,
    DATA1 = 4'b1011,
    ACK   = 4'b0010,
    NAK   = 4'b1010
  } usb_pid_t;

  // packet kind reported at eop
  typedef enum logic [2:0] {
    PKT_IDLE = 3'd0,
    PKT_DATA = 3'd1,
    PKT_OUT  = 3'd2,
    PKT_IN   = 3'd3,
    PKT_ACK  = 3'd4,
    PKT_NAK  = 3'd5,
    PKT_BAD  = 3'd6
  } rx_packet_t;

  typedef enum logic [2:0] {
    IDLE, SYNC, PID, TOKEN, DATA, HSHAKE, WAIT_EOP, DONE
  } rx_state_t;

  // one recovered line event
  typedef struct packed {
    logic strobe;  // new bit valid this cycle
    logic data;    // decoded bit
    logic eop;     // se0 then j seen
  } rx_bit_t;

endpackage

// ==== flist.f ====
+incdir+design
design/usb_rx_pkg.sv
design/usb_line_sampler.sv
design/usb_bit_unstuffer.sv
design/usb_crc_checker.sv
design/usb_rx_fsm.sv
design/usb_rx.sv
tests/usb_rx_assertions.sv
tests/tb_usb_rx.sv

// ==== run.sh ====
#!/bin/sh
# build and run the usb receiver testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_usb_rx -f flist.f -o sim_tb_usb_rx

out=$(./obj_dir/sim_tb_usb_rx 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^STATUS: PASS$"; then
  exit 0
fi
exit 1

// ==== tests/tb_usb_rx.sv ====
`timescale 1ns/10ps
`include "usb_rx_defs.svh"

module tb_usb_rx import usb_rx_pkg::*; ();

  localparam int unsigned BIT_CLKS       = `USB_BIT_CLKS;
  localparam int unsigned TIMEOUT_CYCLES = 15000;  // ~14 packets of <= 100 bits, plus gaps

  typedef usb_byte_t byte_q_t[$];

  logic       tb_clk  = 1'b0;
  logic       rst     = 1'b1;
  logic       d_plus  = 1'b1;  // idle J
  logic       d_minus = 1'b0;
  rx_packet_t rx_packet;
  logic       store_rx_packet_data;
  usb_byte_t  rx_packet_data;

  byte_q_t     stored;            // bytes seen on the store strobe
  byte_q_t     pay;
  logic        line_j    = 1'b1;  // nrzi line level, 1 = J
  int          ones_run  = 0;     // ones since last zero, for stuffing
  int unsigned cycle_cnt = 0;

  usb_rx u_usb_rx (
    .tb_clk               (tb_clk),
    .rst                  (rst),
    .d_plus               (d_plus),
    .d_minus              (d_minus),
    .rx_packet            (rx_packet),
    .store_rx_packet_data (store_rx_packet_data),
    .rx_packet_data       (rx_packet_data)
  );

  always #2 tb_clk = ~tb_clk;  // 4 ns period

  // collect every stored payload byte
  always @(posedge tb_clk) begin
    if (store_rx_packet_data) stored.push_back(rx_packet_data);
  end

  always @(posedge tb_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("TIMEOUT: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_value(input string test_name, input string what,
                             input int expected, input int actual);
    if (expected != actual) begin
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // **************************************************
  // line driver, all changes 1 ns after the edge
  // **************************************************
  task automatic put_line(input logic dp, input logic dm);
    d_plus  = dp;
    d_minus = dm;
    repeat (BIT_CLKS) @(posedge tb_clk);
    #1;
  endtask

  task automatic send_raw(input logic b);
    if (!b) line_j = !line_j;  // zero toggles
    put_line(line_j, !line_j);
  endtask

  task automatic send_bit(input logic b);
    send_raw(b);
    if (!b) begin
      ones_run = 0;
    end else begin
      ones_run++;
      if (ones_run == `USB_STUFF_RUN) begin
        send_raw(1'b0);  // stuffed zero
        ones_run = 0;
      end
    end
  endtask

  task automatic send_byte(input usb_byte_t b);
    for (int i = 7; i >= 0; i--) send_bit(b[i]);  // msb first
  endtask

  // sync, pid, body, se0 x2, then J held for two bit times
  task automatic send_packet(input usb_byte_t pid_b, input byte_q_t body);
    stored.delete();
    line_j   = 1'b1;
    ones_run = 0;
    send_byte(`USB_SYNC_BYTE);
    send_byte(pid_b);
    foreach (body[i]) send_byte(body[i]);
    put_line(1'b0, 1'b0);
    put_line(1'b0, 1'b0);
    d_plus  = 1'b1;
    d_minus = 1'b0;
    repeat (2 * BIT_CLKS) @(posedge tb_clk);  // result due within 16 cycles
    #1;
  endtask

  // **************************************************
  // reference values
  // **************************************************
  function automatic usb_byte_t pid_byte(input logic [3:0] pid);
    return {pid, ~pid};  // check nibble below
  endfunction

  function automatic logic [4:0] crc5_of(input logic [10:0] bits);
    logic [4:0] crc;
    logic       fb;
    crc = 5'h1f;
    for (int i = 10; i >= 0; i--) begin
      fb  = bits[i] ^ crc[4];
      crc = {crc[3:0], 1'b0} ^ (fb ? `USB_CRC5_POLY : 5'd0);
    end
    return ~crc;
  endfunction

  function automatic logic [15:0] crc16_of(input byte_q_t data);
    logic [15:0] crc;
    logic        fb;
    crc = 16'hffff;
    foreach (data[i]) begin
      for (int b = 7; b >= 0; b--) begin
        fb  = data[i][b] ^ crc[15];
        crc = {crc[14:0], 1'b0} ^ (fb ? `USB_CRC16_POLY : 16'd0);
      end
    end
    return ~crc;
  endfunction

  function automatic byte_q_t random_bytes(input int n);
    byte_q_t q;
    repeat (n) q.push_back(usb_byte_t'($urandom));
    return q;
  endfunction

  task automatic check_result(input string name, input rx_packet_t exp_kind,
                              input byte_q_t exp_bytes);
    check_value(name, "packet kind", int'(exp_kind), int'(rx_packet));
    check_value(name, "byte count", exp_bytes.size(), stored.size());
    foreach (exp_bytes[i]) check_value(name, "stored byte", int'(exp_bytes[i]), int'(stored[i]));
  endtask

  // **************************************************
  // directed tests
  // **************************************************
  task automatic test_reset();
    byte_q_t none;
    stored.delete();
    repeat (4 * BIT_CLKS) @(posedge tb_clk);  // idle J only
    #1;
    check_result("reset", PKT_IDLE, none);
  endtask

  task automatic run_token(input string name, input usb_pid_t pid, input logic [6:0] addr,
                           input logic [3:0] endp, input logic zero_crc,
                           input rx_packet_t exp_kind);
    logic [4:0]  crc;
    logic [15:0] tok;
    byte_q_t     body;
    byte_q_t     none;
    crc = zero_crc ? 5'd0 : crc5_of({addr, endp});
    tok = {addr, endp, crc};  // addr, endp, crc5 msb first
    body.push_back(tok[15:8]);
    body.push_back(tok[7:0]);
    send_packet(pid_byte(pid), body);
    check_result(name, exp_kind, none);
  endtask

  task automatic run_handshake(input string name, input usb_pid_t pid,
                               input rx_packet_t exp_kind);
    byte_q_t none;
    send_packet(pid_byte(pid), none);
    check_result(name, exp_kind, none);
  endtask

  task automatic run_data(input string name, input usb_pid_t pid, input byte_q_t payload,
                          input logic zero_crc, input logic flip_byte,
                          input rx_packet_t exp_kind);
    logic [15:0] crc;
    byte_q_t     sent;
    byte_q_t     body;
    crc  = crc16_of(payload);
    sent = payload;
    if (zero_crc) crc = 16'h0000;
    if (flip_byte) sent[1] = sent[1] ^ 8'h5a;  // damaged after crc is fixed
    body = sent;
    body.push_back(crc[15:8]);
    body.push_back(crc[7:0]);
    send_packet(pid_byte(pid), body);
    check_result(name, exp_kind, sent);  // bytes stay stored even when bad
  endtask

  task automatic run_bad_pid();
    byte_q_t none;
    send_packet({DATA0, DATA0}, none);  // lower nibble not inverted
    check_result("bad_pid", PKT_BAD, none);
  endtask

  initial begin
    void'($urandom(47));
    repeat (2) @(posedge tb_clk);
    #1;
    rst = 1'b0;
    test_reset();
    run_token("in_token", IN, `USB_DEV_ADDR, `USB_DEV_ENDP, 1'b0, PKT_IN);
    run_token("out_token", OUT, `USB_DEV_ADDR, `USB_DEV_ENDP, 1'b0, PKT_OUT);
    run_token("in_other_addr", IN, 7'd1, `USB_DEV_ENDP, 1'b0, PKT_IDLE);
    run_token("out_other_endp", OUT, `USB_DEV_ADDR, 4'd1, 1'b0, PKT_IDLE);
    run_token("in_zero_crc5", IN, `USB_DEV_ADDR, `USB_DEV_ENDP, 1'b1, PKT_BAD);
    run_handshake("ack", ACK, PKT_ACK);
    run_handshake("nak", NAK, PKT_NAK);
    pay = random_bytes(4);
    run_data("data0", DATA0, pay, 1'b0, 1'b0, PKT_DATA);
    pay = random_bytes(4);
    run_data("data1", DATA1, pay, 1'b0, 1'b0, PKT_DATA);
    pay = random_bytes(4);
    run_data("data0_zero_crc16", DATA0, pay, 1'b1, 1'b0, PKT_BAD);
    pay = random_bytes(4);
    run_data("data1_bad_byte", DATA1, pay, 1'b0, 1'b1, PKT_BAD);
    pay.delete();
    pay.push_back(8'hFF);  // long runs of ones force stuffing
    pay.push_back(8'hFF);
    pay.push_back(8'h7E);
    run_data("data0_stuffed", DATA0, pay, 1'b0, 1'b0, PKT_DATA);
    run_bad_pid();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== tests/usb_rx_assertions.sv ====
`timescale 1ns/10ps

module usb_rx_assertions import usb_rx_pkg::*; (
  input logic       tb_clk,
  input logic       rst,
  input rx_packet_t rx_packet,
  input logic       store_rx_packet_data,
  input usb_byte_t  rx_packet_data
);

  // at most one byte per strobe cycle
  store_one_cycle: assert property (@(posedge tb_clk) disable iff (rst)
    store_rx_packet_data |=> !store_rx_packet_data)
    else $error("store strobe high in two consecutive cycles");

  // bytes only stream between sync and eop
  store_in_packet: assert property (@(posedge tb_clk) disable iff (rst)
    store_rx_packet_data |-> rx_packet == PKT_IDLE)
    else $error("byte stored while a packet result is still shown");

  // outputs back to idle right after reset
  idle_after_reset: assert property (@(posedge tb_clk)
    rst |=> (rx_packet == PKT_IDLE && !store_rx_packet_data && rx_packet_data == '0))
    else $error("outputs not idle after reset");

endmodule

bind usb_rx usb_rx_assertions u_usb_rx_assertions (
  .tb_clk(tb_clk), .rst(rst), .rx_packet(rx_packet),
  .store_rx_packet_data(store_rx_packet_data), .rx_packet_data(rx_packet_data)
);
